// ==== vlog.f ====
+incdir+rtl
rtl/exc_pkg.sv
rtl/cp0_regs.sv
rtl/exception_unit.sv
rtl/fetch_pc.sv
rtl/exc_top.sv
verif/tb_clock.sv
verif/tb_exc_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_exc_top \
    -o tb_exc_top_sim > sim.log 2>&1 &&
    ./obj_dir/tb_exc_top_sim >> sim.log 2>&1 ||
    echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// ==== verif/tb_exc_top.sv ====
`timescale 1ns/1ps
`include "exc_settings.svh"

module tb_exc_top;
    import exc_pkg::*;

    logic        clk;
    logic        rst_n;
    logic [5:0]  ext_int;
    logic        flag_fetch_adel;
    logic        flag_ri;
    logic        flag_ov;
    logic        flag_sys;
    logic        flag_bp;
    logic        flag_load_adel;
    logic        flag_store_ades;
    logic [31:0] commit_pc;
    logic        in_delay_slot;
    logic [31:0] badvaddr;
    logic        eret;
    logic        cp0_we;
    cp0_addr_t   cp0_waddr;
    logic [31:0] cp0_wdata;
    cp0_addr_t   cp0_raddr;
    logic [31:0] cp0_rdata;
    logic        stall;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic [31:0] pc;
    logic        exc_valid;
    exc_code_t   exc_code;

    // reference model state
    logic [31:0] m_status;
    // stored cause fields while IP[7:2] comes live from the inputs
    logic [31:0] m_cause;
    logic [31:0] m_epc;
    logic [31:0] m_badv;
    logic [31:0] m_count;
    logic [31:0] m_compare;
    logic [31:0] m_pc;
    logic        m_timer;
    logic        m_int_pend;
    // model view of the cycle being checked
    logic        exp_valid;
    exc_code_t   exp_code;
    logic        int_qual;

    tb_clock u_clock (.clk(clk));

    exc_top u_dut (.*);

    function automatic bit chance(input int unsigned pct);
        return ($urandom % 100) < pct;
    endfunction

    // mostly real registers and now and then an unmapped number
    function automatic cp0_addr_t pick_addr();
        case ($urandom % 8)
            0: return BADVADDR;
            1: return COUNT;
            2: return COMPARE;
            3, 4: return STATUS;
            5: return CAUSE;
            6: return EPC;
            default: return cp0_addr_t'(5'd3);
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic set_idle();
        {flag_fetch_adel, flag_ri, flag_ov, flag_sys} = 4'b0000;
        {flag_bp, flag_load_adel, flag_store_ades} = 3'b000;
        ext_int = 6'd0;
        commit_pc = 32'h0000_1000;
        in_delay_slot = 1'b0;
        badvaddr = 32'd0;
        eret = 1'b0;
        stall = 1'b0;
        branch_taken = 1'b0;
        branch_target = 32'd0;
        cp0_we = 1'b0;
        cp0_waddr = COUNT;
        cp0_wdata = 32'd0;
        cp0_raddr = STATUS;
    endtask

    task automatic randomize_inputs();
        flag_fetch_adel = chance(3);
        flag_ri = chance(3);
        flag_ov = chance(3);
        flag_sys = chance(3);
        flag_bp = chance(3);
        flag_load_adel = chance(3);
        flag_store_ades = chance(3);
        // one hardware line at a time
        ext_int = chance(4) ? 6'(1 << ($urandom % 6)) : 6'd0;
        commit_pc = $urandom & 32'hFFFF_FFFC;
        in_delay_slot = chance(50);
        badvaddr = $urandom;
        eret = chance(3);
        stall = chance(20);
        branch_taken = chance(10);
        branch_target = $urandom & 32'hFFFF_FFFC;
        cp0_raddr = pick_addr();
        cp0_we = chance(10);
        cp0_waddr = pick_addr();
        cp0_wdata = $urandom;
        // status writes lean towards interrupts enabled
        if (cp0_waddr == STATUS) begin
            if (chance(90)) cp0_wdata[2] = 1'b0;
            if (chance(70)) cp0_wdata[1] = 1'b0;
            if (chance(80)) cp0_wdata[0] = 1'b1;
        end
        // compare just ahead of count
        if (cp0_waddr == COMPARE && chance(50)) begin
            cp0_wdata = m_count + 32'd2 + ($urandom % 6);
        end
        // eret target has to stay word aligned
        if (cp0_waddr == EPC) cp0_wdata[1:0] = 2'b00;
    endtask

    // check 1 ns after the drive and step the model at the rising edge
    task automatic run_cycle();
        logic [7:0]  pend;
        logic [31:0] exp_rd;
        #1;
        pend = {ext_int, m_cause[9:8]} | {m_timer, 7'd0};
        int_qual = ((pend & m_status[15:8]) != 8'd0) && m_status[0]
                   && !m_status[1] && !m_status[2];
        // latched interrupt goes before the commit flags
        exp_valid = 1'b1;
        if (m_int_pend) exp_code = INT;
        else if (flag_fetch_adel) exp_code = ADEL;
        else if (flag_ri) exp_code = RI;
        else if (flag_ov) exp_code = OV;
        else if (flag_sys) exp_code = SYS;
        else if (flag_bp) exp_code = BP;
        else if (flag_load_adel) exp_code = ADEL;
        else if (flag_store_ades) exp_code = ADES;
        else begin
            exp_valid = 1'b0;
            exp_code = INT;
        end
        case (cp0_raddr)
            BADVADDR: exp_rd = m_badv;
            COUNT:    exp_rd = m_count;
            COMPARE:  exp_rd = m_compare;
            STATUS:   exp_rd = m_status;
            CAUSE:    exp_rd = {m_cause[31:16], pend, m_cause[7:0]};
            EPC:      exp_rd = m_epc;
            default:  exp_rd = 32'd0;
        endcase
        check_value("exc_valid", {31'd0, exc_valid}, {31'd0, exp_valid});
        if (exp_valid) check_value("exc_code", {27'd0, exc_code}, {27'd0, exp_code});
        check_value("pc", pc, m_pc);
        check_value($sformatf("cp0_rdata reg %0d", cp0_raddr), cp0_rdata, exp_rd);
        @(posedge clk);
        // pc uses the old epc and the timer uses the old count and compare
        if (exp_valid) m_pc = `EXC_ENTRY;
        else if (eret) m_pc = m_epc;
        else if (branch_taken) m_pc = branch_target;
        else if (!stall) m_pc = m_pc + 32'd4;
        if (cp0_we && cp0_waddr == COMPARE) m_timer = 1'b0;
        else if (m_count == m_compare) m_timer = 1'b1;
        if (exp_valid) m_int_pend = 1'b0;
        else if (int_qual) m_int_pend = 1'b1;
        if (cp0_we && cp0_waddr == STATUS) begin
            m_status = (m_status & ~`STATUS_WMASK) | (cp0_wdata & `STATUS_WMASK);
        end
        if (exp_valid) m_status[1] = 1'b1;
        else if (eret) m_status[1] = 1'b0;
        if (cp0_we && cp0_waddr == CAUSE) begin
            m_cause = (m_cause & ~`CAUSE_WMASK) | (cp0_wdata & `CAUSE_WMASK);
        end
        if (exp_valid) begin
            m_cause[31] = in_delay_slot;
            m_cause[6:2] = exp_code;
            m_epc = in_delay_slot ? commit_pc - 32'd4 : commit_pc;
        end else if (cp0_we && cp0_waddr == EPC) begin
            m_epc = cp0_wdata;
        end
        if (exp_valid && (exp_code == ADEL || exp_code == ADES)) m_badv = badvaddr;
        if (cp0_we && cp0_waddr == COUNT) m_count = cp0_wdata;
        else m_count = m_count + 32'd1;
        if (cp0_we && cp0_waddr == COMPARE) m_compare = cp0_wdata;
        @(negedge clk);
    endtask

    // quiet pipeline with the timer as the only source through IM[7]
    task automatic timer_interrupt();
        int waited;
        set_idle();
        cp0_we = 1'b1;
        cp0_waddr = STATUS;
        run_cycle();
        // let a leftover latched interrupt drain
        set_idle();
        run_cycle();
        run_cycle();
        cp0_we = 1'b1;
        cp0_waddr = COMPARE;
        cp0_wdata = m_count + 32'd6;
        run_cycle();
        cp0_waddr = STATUS;
        cp0_wdata = 32'h0000_8001;
        run_cycle();
        set_idle();
        cp0_raddr = CAUSE;
        waited = 0;
        do begin
            run_cycle();
            waited++;
        end while (!(exp_valid && exp_code == INT) && waited < 40);
        if (!(exp_valid && exp_code == INT)) begin
            $display("timer interrupt was not taken within 40 cycles");
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        void'($urandom(32'h76d7));
        rst_n = 1'b0;
        set_idle();
        // reset values have BEV and ERL set
        m_status = (32'd1 << 22) | (32'd1 << 2);
        m_cause = 32'd0;
        m_epc = 32'd0;
        m_badv = 32'd0;
        m_count = 32'd0;
        m_compare = 32'd0;
        m_timer = 1'b0;
        m_int_pend = 1'b0;
        m_pc = `RESET_PC;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < 3000; i++) begin
            randomize_inputs();
            run_cycle();
        end
        timer_interrupt();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 4 ns period starting low
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

// ==== rtl/exc_top.sv ====
`timescale 1ns/1ps

module exc_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [5:0]          ext_int,
    // commit stage exception flags
    input  logic                flag_fetch_adel,
    input  logic                flag_ri,
    input  logic                flag_ov,
    input  logic                flag_sys,
    input  logic                flag_bp,
    input  logic                flag_load_adel,
    input  logic                flag_store_ades,
    input  logic [31:0]         commit_pc,
    input  logic                in_delay_slot,
    input  logic [31:0]         badvaddr,
    input  logic                eret,
    // mtc0 / mfc0 side
    input  logic                cp0_we,
    input  exc_pkg::cp0_addr_t  cp0_waddr,
    input  logic [31:0]         cp0_wdata,
    input  exc_pkg::cp0_addr_t  cp0_raddr,
    output logic [31:0]         cp0_rdata,
    // fetch side
    input  logic                stall,
    input  logic                branch_taken,
    input  logic [31:0]         branch_target,
    output logic [31:0]         pc,
    // the taken exception doubles as the pipeline flush
    output logic                exc_valid,
    output exc_pkg::exc_code_t  exc_code
);

    logic        status_ie;
    logic        status_exl;
    logic        status_erl;
    logic [7:0]  status_im;
    logic [7:0]  cause_ip;
    logic [31:0] epc;

    exception_unit u_exception_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .ext_int         (ext_int),
        .cause_ip        (cause_ip),
        .status_ie       (status_ie),
        .status_exl      (status_exl),
        .status_erl      (status_erl),
        .status_im       (status_im),
        .flag_fetch_adel (flag_fetch_adel),
        .flag_ri         (flag_ri),
        .flag_ov         (flag_ov),
        .flag_sys        (flag_sys),
        .flag_bp         (flag_bp),
        .flag_load_adel  (flag_load_adel),
        .flag_store_ades (flag_store_ades),
        .exc_valid       (exc_valid),
        .exc_code        (exc_code)
    );

    cp0_regs u_cp0_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .ext_int       (ext_int),
        .exc_valid     (exc_valid),
        .exc_code      (exc_code),
        .commit_pc     (commit_pc),
        .in_delay_slot (in_delay_slot),
        .badvaddr      (badvaddr),
        .eret          (eret),
        .cp0_we        (cp0_we),
        .cp0_waddr     (cp0_waddr),
        .cp0_wdata     (cp0_wdata),
        .cp0_raddr     (cp0_raddr),
        .cp0_rdata     (cp0_rdata),
        .status_ie     (status_ie),
        .status_exl    (status_exl),
        .status_erl    (status_erl),
        .status_im     (status_im),
        .cause_ip      (cause_ip),
        .epc           (epc)
    );

    fetch_pc u_fetch_pc (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .exc_valid     (exc_valid),
        .eret          (eret),
        .epc           (epc),
        .pc            (pc)
    );

endmodule

// ==== rtl/fetch_pc.sv ====
`timescale 1ns/1ps
`include "exc_settings.svh"

module fetch_pc (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        branch_taken,
    input  logic [31:0] branch_target,
    input  logic        exc_valid,
    input  logic        eret,
    input  logic [31:0] epc,
    output logic [31:0] pc
);

    logic [31:0] pc_next;

    // redirect order is exception, eret, branch, stall and then sequential
    // stall only holds the sequential path
    always_comb begin
        if (exc_valid) begin
            pc_next = `EXC_ENTRY;
        end else if (eret) begin
            pc_next = epc;
        end else if (branch_taken) begin
            pc_next = branch_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // all redirect sources must deliver word addresses
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// ==== rtl/exception_unit.sv ====
`timescale 1ns/1ps

module exception_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [5:0]          ext_int,
    input  logic [7:0]          cause_ip,
    input  logic                status_ie,
    input  logic                status_exl,
    input  logic                status_erl,
    input  logic [7:0]          status_im,
    input  logic                flag_fetch_adel,
    input  logic                flag_ri,
    input  logic                flag_ov,
    input  logic                flag_sys,
    input  logic                flag_bp,
    input  logic                flag_load_adel,
    input  logic                flag_store_ades,
    output logic                exc_valid,
    output exc_pkg::exc_code_t  exc_code
);
    import exc_pkg::*;

    logic [7:0] pending;
    logic [7:0] int_req;
    logic       int_qual;
    // interrupt taken on the next commit
    logic       int_pend;

    // external lines also come straight in at their cause positions
    assign pending = cause_ip | {ext_int, 2'b00};
    assign int_req = pending & status_im;

    // no nesting while in exception or error level
    assign int_qual = (int_req != 8'd0) && status_ie && !status_exl && !status_erl;

    // latch the request and drop it once an exception is taken
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_pend <= 1'b0;
        end else if (exc_valid) begin
            int_pend <= 1'b0;
        end else if (int_qual) begin
            int_pend <= 1'b1;
        end
    end

    // priority pick with the interrupt first and then pipeline-stage order
    always_comb begin
        exc_valid = 1'b1;
        exc_code  = INT;
        priority case (1'b1)
            int_pend: begin
                exc_code = INT;
            end
            // fetch stage
            flag_fetch_adel: begin
                exc_code = ADEL;
            end
            // decode
            flag_ri: begin
                exc_code = RI;
            end
            // execute
            flag_ov: begin
                exc_code = OV;
            end
            flag_sys: begin
                exc_code = SYS;
            end
            flag_bp: begin
                exc_code = BP;
            end
            // memory stage
            flag_load_adel: begin
                exc_code = ADEL;
            end
            flag_store_ades: begin
                exc_code = ADES;
            end
            default: begin
                exc_valid = 1'b0;
                exc_code  = INT;
            end
        endcase
    end

    // a latched interrupt owns exactly one commit and then clears
    a_int_taken: assert property (@(posedge clk) disable iff (!rst_n)
        int_pend |-> (exc_valid && exc_code == INT) ##1 !int_pend);

endmodule

// ==== rtl/cp0_regs.sv ====
`timescale 1ns/1ps
`include "exc_settings.svh"

module cp0_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [5:0]           ext_int,
    input  logic                 exc_valid,
    input  exc_pkg::exc_code_t   exc_code,
    input  logic [31:0]          commit_pc,
    input  logic                 in_delay_slot,
    input  logic [31:0]          badvaddr,
    input  logic                 eret,
    input  logic                 cp0_we,
    input  exc_pkg::cp0_addr_t   cp0_waddr,
    input  logic [31:0]          cp0_wdata,
    input  exc_pkg::cp0_addr_t   cp0_raddr,
    output logic [31:0]          cp0_rdata,
    output logic                 status_ie,
    output logic                 status_exl,
    output logic                 status_erl,
    output logic [7:0]           status_im,
    output logic [7:0]           cause_ip,
    output logic [31:0]          epc
);
    import exc_pkg::*;

    logic [31:0] status_q;
    // BD, software IP and ExcCode live here
    logic [31:0] cause_q;
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic        timer_ip;
    logic        addr_exc;
    logic [31:0] cause_rd;

    // only address errors report a faulting address
    assign addr_exc = exc_valid && (exc_code == ADEL || exc_code == ADES);

    // status takes the masked write, then entry or eret override EXL
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // BEV=1, ERL=1, everything else clear
            status_q <= 32'h0040_0004;
        end else begin
            if (cp0_we && cp0_waddr == STATUS) begin
                status_q <= (status_q & ~`STATUS_WMASK) | (cp0_wdata & `STATUS_WMASK);
            end
            // entry sets EXL and eret clears it over any write
            if (exc_valid) begin
                status_q[1] <= 1'b1;
            end else if (eret) begin
                status_q[1] <= 1'b0;
            end
        end
    end

    // cause takes the software IP write and BD and ExcCode on entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cause_q <= '0;
        end else begin
            if (cp0_we && cp0_waddr == CAUSE) begin
                cause_q <= (cause_q & ~`CAUSE_WMASK) | (cp0_wdata & `CAUSE_WMASK);
            end
            if (exc_valid) begin
                cause_q[31]  <= in_delay_slot;
                cause_q[6:2] <= exc_code;
            end
        end
    end

    // epc returns to the branch when the fault sits in its delay slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            epc_q <= '0;
        end else if (exc_valid) begin
            epc_q <= in_delay_slot ? commit_pc - 32'd4 : commit_pc;
        end else if (cp0_we && cp0_waddr == EPC) begin
            epc_q <= cp0_wdata;
        end
    end

    // badvaddr is read only to software
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            badvaddr_q <= '0;
        end else if (addr_exc) begin
            badvaddr_q <= badvaddr;
        end
    end

    // count ticks every cycle unless a write replaces the tick
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (cp0_we && cp0_waddr == COUNT) begin
            count_q <= cp0_wdata;
        end else begin
            count_q <= count_q + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            compare_q <= '0;
        end else if (cp0_we && cp0_waddr == COMPARE) begin
            compare_q <= cp0_wdata;
        end
    end

    // timer request stays set until compare is rewritten
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer_ip <= 1'b0;
        end else if (cp0_we && cp0_waddr == COMPARE) begin
            timer_ip <= 1'b0;
        end else if (count_q == compare_q) begin
            timer_ip <= 1'b1;
        end
    end

    // pending vector with hw lines on 7:2 and sw on 1:0
    // timer shares line 7
    assign cause_ip = {ext_int, cause_q[9:8]} | {timer_ip, 7'b0};

    assign status_ie  = status_q[0];
    assign status_exl = status_q[1];
    assign status_erl = status_q[2];
    assign status_im  = status_q[15:8];
    assign epc        = epc_q;

    // live IP bits replace the stored field on reads
    assign cause_rd = {cause_q[31:16], cause_ip, cause_q[7:0]};

    // read port gives zero for unlisted numbers
    always_comb begin
        case (cp0_raddr)
            BADVADDR: cp0_rdata = badvaddr_q;
            COUNT:    cp0_rdata = count_q;
            COMPARE:  cp0_rdata = compare_q;
            STATUS:   cp0_rdata = status_q;
            CAUSE:    cp0_rdata = cause_rd;
            EPC:      cp0_rdata = epc_q;
            default:  cp0_rdata = '0;
        endcase
    end

    // boot vector select must survive reset and every masked write
    a_bev_set: assert property (@(posedge clk) disable iff (!rst_n) status_q[22]);

endmodule

// ==== rtl/exc_pkg.sv ====
package exc_pkg;

    // Cause.ExcCode values
    // only the codes this core can raise
    typedef enum logic [4:0] {
        // interrupt from the latched request
        INT  = 5'd0,
        // address error on fetch or load
        ADEL = 5'd4,
        // address error on store
        ADES = 5'd5,
        // syscall instruction
        SYS  = 5'd8,
        // break instruction
        BP   = 5'd9,
        // reserved instruction
        RI   = 5'd10,
        // signed add/sub overflow
        OV   = 5'd12
    } exc_code_t;

    // cp0 register numbers for select 0 only
    // any other number reads as zero
    typedef enum logic [4:0] {
        // read only faulting address
        BADVADDR = 5'd8,
        // free running cycle counter
        COUNT    = 5'd9,
        // timer match value
        COMPARE  = 5'd11,
        // IE, EXL, ERL, IM, BEV
        STATUS   = 5'd12,
        // BD, IP, ExcCode
        CAUSE    = 5'd13,
        // return address for eret
        EPC      = 5'd14
    } cp0_addr_t;

endpackage

// ==== rtl/exc_settings.svh ====
`ifndef EXC_SETTINGS_SVH
`define EXC_SETTINGS_SVH

// single exception vector without BEV/EXL offset selection
`define EXC_ENTRY 32'hBFC0_0380

// boot address out of reset
`define RESET_PC 32'hBFC0_0000

// status bits software may write
// IE bit 0, EXL bit 1, ERL bit 2, IM bits 15:8
// BEV (bit 22) stays at 1 and is not in the mask
`define STATUS_WMASK 32'h0000_FF07

// cause bits software may write
// only the two software interrupt bits IP[1:0]
`define CAUSE_WMASK 32'h0000_0300

`endif
